// File: hw/fetch_pkg.sv
package fetch_pkg;

    // cache geometry, index taken over halfword addresses
    localparam int INDEX_BITS = 6;
    localparam int CACHE_SIZE = 1 << INDEX_BITS;
    localparam int TAG_BITS   = 32 - INDEX_BITS - 1;

    // credits the memory grants after reset
    localparam int MEM_CREDITS = 2;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // wide enough to hold MEM_CREDITS itself
    typedef logic [$clog2(MEM_CREDITS + 1)-1:0] credit_t;

    typedef enum logic [1:0] {
        FILL_IDLE,  // no miss in service
        FILL_SEND,  // address latched, waiting for a credit
        FILL_WAIT   // request sent, waiting for the response
    } fill_state_e;

endpackage

// File: hw/miss_if.sv
`timescale 1ns/1ps

interface miss_if;
    import fetch_pkg::*;

    logic        miss_valid;  // held until the fill for miss_addr arrives
    addr_t       miss_addr;
    logic        fill_valid;
    addr_t       fill_addr;
    word_t       fill_data;   // {halfword at addr+2, halfword at addr}
    fill_state_e fill_state;

    modport requester (
        output miss_valid,
        output miss_addr,
        input  fill_valid,
        input  fill_addr,
        input  fill_data,
        input  fill_state
    );

    modport filler (
        input  miss_valid,
        input  miss_addr,
        output fill_valid,
        output fill_addr,
        output fill_data,
        output fill_state
    );

    modport cache (
        input fill_valid,
        input fill_addr,
        input fill_data
    );

endinterface

// File: hw/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic             clk_in,
    input  logic             rst_in,
    input  fetch_pkg::addr_t lookup_addr,
    miss_if.cache            fill,
    output logic             hit_lo,
    output logic             hit_hi,
    output fetch_pkg::word_t lookup_data
);
    import fetch_pkg::*;

    logic                valid_q [CACHE_SIZE];
    logic [TAG_BITS-1:0] tag_q   [CACHE_SIZE];
    logic [15:0]         data_q  [CACHE_SIZE];

    addr_t               rd_addr_hi;
    logic [INDEX_BITS-1:0] rd_idx_lo;
    logic [INDEX_BITS-1:0] rd_idx_hi;
    logic [TAG_BITS-1:0] rd_tag_lo;
    logic [TAG_BITS-1:0] rd_tag_hi;

    addr_t               wr_addr_hi;
    logic [INDEX_BITS-1:0] wr_idx_lo;
    logic [INDEX_BITS-1:0] wr_idx_hi;
    logic [TAG_BITS-1:0] wr_tag_lo;
    logic [TAG_BITS-1:0] wr_tag_hi;

    // lookup side, two halfwords checked on their own
    assign rd_addr_hi = lookup_addr + 32'd2;
    assign rd_idx_lo  = lookup_addr[INDEX_BITS:1];
    assign rd_idx_hi  = rd_addr_hi[INDEX_BITS:1];
    assign rd_tag_lo  = lookup_addr[31:INDEX_BITS+1];
    assign rd_tag_hi  = rd_addr_hi[31:INDEX_BITS+1];

    assign hit_lo = valid_q[rd_idx_lo] && (tag_q[rd_idx_lo] == rd_tag_lo);
    assign hit_hi = valid_q[rd_idx_hi] && (tag_q[rd_idx_hi] == rd_tag_hi);
    assign lookup_data = {data_q[rd_idx_hi], data_q[rd_idx_lo]};

    // fill side, a word lands as two halfword entries
    assign wr_addr_hi = fill.fill_addr + 32'd2;
    assign wr_idx_lo  = fill.fill_addr[INDEX_BITS:1];
    assign wr_idx_hi  = wr_addr_hi[INDEX_BITS:1];
    assign wr_tag_lo  = fill.fill_addr[31:INDEX_BITS+1];
    assign wr_tag_hi  = wr_addr_hi[31:INDEX_BITS+1];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < CACHE_SIZE; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (fill.fill_valid) begin
            valid_q[wr_idx_lo] <= 1'b1;
            valid_q[wr_idx_hi] <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (fill.fill_valid) begin
            tag_q[wr_idx_lo]  <= wr_tag_lo;
            data_q[wr_idx_lo] <= fill.fill_data[15:0];
            tag_q[wr_idx_hi]  <= wr_tag_hi;  // may differ from lo tag across index wrap
            data_q[wr_idx_hi] <= fill.fill_data[31:16];
        end
    end

endmodule

// File: hw/line_fill.sv
`timescale 1ns/1ps

module line_fill (
    input  logic             clk_in,
    input  logic             rst_in,
    miss_if.filler           port,
    output logic             mem_req_valid,
    output fetch_pkg::addr_t mem_req_addr,
    input  logic             mem_credit,
    input  logic             mem_resp_valid,
    input  fetch_pkg::word_t mem_resp_data
);
    import fetch_pkg::*;

    fill_state_e state_q;
    fill_state_e state_d;
    addr_t       req_addr_q;
    credit_t     credits_q;
    logic        can_send;

    assign can_send      = (credits_q != '0);
    assign mem_req_valid = (state_q == FILL_SEND) && can_send;
    assign mem_req_addr  = req_addr_q;

    // response forwarded in the same cycle it arrives
    assign port.fill_valid = (state_q == FILL_WAIT) && mem_resp_valid;
    assign port.fill_addr  = req_addr_q;
    assign port.fill_data  = mem_resp_data;
    assign port.fill_state = state_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FILL_IDLE: begin
                if (port.miss_valid) begin
                    state_d = FILL_SEND;
                end
            end
            FILL_SEND: begin
                if (can_send) begin
                    state_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (mem_resp_valid) begin
                    state_d = FILL_IDLE;
                end
            end
            default: state_d = FILL_IDLE;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state_q <= FILL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address is only looked at outside FILL_IDLE
    always_ff @(posedge clk_in) begin
        if (state_q == FILL_IDLE && port.miss_valid) begin
            req_addr_q <= port.miss_addr;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            credits_q <= credit_t'(MEM_CREDITS);
        end else begin
            case ({mem_req_valid, mem_credit})
                2'b10: credits_q <= credits_q - 1'b1;
                2'b01: begin
                    if (credits_q != credit_t'(MEM_CREDITS)) begin
                        credits_q <= credits_q + 1'b1;  // saturate at grant
                    end
                end
                default: credits_q <= credits_q;  // none, or spend and return together
            endcase
        end
    end

endmodule

// File: hw/fetch_align.sv
`timescale 1ns/1ps

module fetch_align (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    output fetch_pkg::addr_t lookup_addr,
    input  logic             hit_lo,
    input  logic             hit_hi,
    input  fetch_pkg::word_t lookup_data,
    miss_if.requester        port,
    output logic             inst_valid,
    output fetch_pkg::word_t inst,
    output fetch_pkg::word_t inst_pc,
    output logic             inst_compressed,
    input  logic             inst_ready
);
    import fetch_pkg::*;

    addr_t       pc_q;
    addr_t       pc_plus2;
    logic        fill_at_pc;
    logic        fill_below_pc;
    logic        fill_at_next;
    logic        lo_ok;
    logic        hi_ok;
    logic [15:0] lo_half;
    logic [15:0] hi_half;
    logic        is_rvc;
    logic        avail;
    logic        accept;
    logic        miss_q;
    addr_t       miss_addr_q;

    assign lookup_addr = pc_q;
    assign pc_plus2    = pc_q + 32'd2;

    // where a fill word sits relative to the pc
    assign fill_at_pc    = port.fill_valid && (port.fill_addr == pc_q);
    assign fill_below_pc = port.fill_valid && (port.fill_addr + 32'd2 == pc_q);
    assign fill_at_next  = port.fill_valid && (port.fill_addr == pc_plus2);

    always_comb begin
        lo_ok   = hit_lo;
        lo_half = lookup_data[15:0];
        hi_ok   = hit_hi;
        hi_half = lookup_data[31:16];
        if (!hit_lo) begin
            if (fill_at_pc) begin
                lo_ok   = 1'b1;
                lo_half = port.fill_data[15:0];
            end else if (fill_below_pc) begin
                lo_ok   = 1'b1;
                lo_half = port.fill_data[31:16];
            end
        end
        if (!hit_hi) begin
            if (fill_at_pc) begin
                hi_ok   = 1'b1;
                hi_half = port.fill_data[31:16];
            end else if (fill_at_next) begin
                hi_ok   = 1'b1;
                hi_half = port.fill_data[15:0];
            end
        end
    end

    assign is_rvc = (lo_half[1:0] != 2'b11);
    assign avail  = lo_ok && (is_rvc || hi_ok);
    assign accept = inst_valid && inst_ready;

    assign inst_valid      = avail && !redirect_valid;
    assign inst            = is_rvc ? {16'h0, lo_half} : {hi_half, lo_half};
    assign inst_pc         = pc_q;
    assign inst_compressed = is_rvc;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc_q <= '0;
        end else if (redirect_valid) begin
            pc_q <= redirect_pc;
        end else if (accept) begin
            pc_q <= is_rvc ? pc_plus2 : pc_q + 32'd4;
        end
    end

    // wait for an idle fill unit, an in-flight word for the pc then arrives on the bypass
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            miss_q <= 1'b0;
        end else if (redirect_valid) begin
            miss_q <= 1'b0;
        end else if (miss_q) begin
            if (port.fill_valid && port.fill_addr == miss_addr_q) begin
                miss_q <= 1'b0;
            end
        end else if (!avail && port.fill_state == FILL_IDLE) begin
            miss_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!miss_q && !avail) begin
            miss_addr_q <= pc_q;
        end
    end

    assign port.miss_valid = miss_q;
    assign port.miss_addr  = miss_addr_q;

endmodule

// File: hw/fetch_front.sv
`timescale 1ns/1ps

module fetch_front (
    input  logic             clk_in,
    input  logic             rst_in,

    // back end
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,

    // decoder
    output logic             inst_valid,
    output fetch_pkg::word_t inst,
    output fetch_pkg::word_t inst_pc,
    output logic             inst_compressed,
    input  logic             inst_ready,

    // memory
    output logic             mem_req_valid,
    output fetch_pkg::addr_t mem_req_addr,
    input  logic             mem_credit,
    input  logic             mem_resp_valid,
    input  fetch_pkg::word_t mem_resp_data
);
    import fetch_pkg::*;

    addr_t lookup_addr;
    word_t lookup_data;
    logic  hit_lo;
    logic  hit_hi;

    miss_if miss_bus ();

    icache u_icache (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .lookup_addr (lookup_addr),
        .fill        (miss_bus.cache),
        .hit_lo      (hit_lo),
        .hit_hi      (hit_hi),
        .lookup_data (lookup_data)
    );

    line_fill u_line_fill (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .port           (miss_bus.filler),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_credit     (mem_credit),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    fetch_align u_fetch_align (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .lookup_addr     (lookup_addr),
        .hit_lo          (hit_lo),
        .hit_hi          (hit_hi),
        .lookup_data     (lookup_data),
        .port            (miss_bus.requester),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .inst_pc         (inst_pc),
        .inst_compressed (inst_compressed),
        .inst_ready      (inst_ready)
    );

endmodule

// File: verif/fetch_front_tb.sv
`timescale 1ns/1ps

module fetch_front_tb;
    import fetch_pkg::*;

    localparam int MAX_TESTS = 16;

    logic  clk_in = 1'b0;
    logic  rst_in;
    logic  redirect_valid;
    addr_t redirect_pc;
    logic  inst_valid;
    word_t inst;
    word_t inst_pc;
    logic  inst_compressed;
    logic  inst_ready;
    logic  mem_req_valid;
    addr_t mem_req_addr;
    logic  mem_credit;
    logic  mem_resp_valid;
    word_t mem_resp_data;

    logic [15:0]     image [256];  // halfwords 0x000 to 0x1fe
    logic [8*24-1:0] t_name [MAX_TESTS];
    addr_t           t_pc [MAX_TESTS];
    int              t_count [MAX_TESTS];
    int              t_ready [MAX_TESTS];
    int              n_tests;
    int              limit_cycles = 0;
    logic [8*24-1:0] cur_name;

    word_t       exp_pc_q [$];
    word_t       exp_inst_q [$];
    logic        exp_rvc_q [$];
    logic [63:0] resp_q [$];  // {due cycle, address}
    addr_t       resp_addr_cur;

    logic                mc_valid [CACHE_SIZE];  // shadow of the cache tags
    logic [TAG_BITS-1:0] mc_tag [CACHE_SIZE];

    int    cycle_cnt;
    int    since_reset;
    int    outstanding;
    int    credit_pending;
    int    checked;
    int    value_errors;
    int    other_errors;
    logic  held;
    word_t held_inst;
    word_t held_pc;

    fetch_front UUT (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .inst_pc         (inst_pc),
        .inst_compressed (inst_compressed),
        .inst_ready      (inst_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req_addr    (mem_req_addr),
        .mem_credit      (mem_credit),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_data   (mem_resp_data)
    );

    always #5 clk_in = ~clk_in;

    function automatic logic [15:0] fill_pattern(input addr_t a);
        return a[31:16] ^ a[15:0] ^ 16'hc3a5;
    endfunction

    function automatic logic [15:0] read_half(input addr_t a);
        if (a < 32'd512) begin
            return image[a[8:1]];
        end
        return fill_pattern(a);
    endfunction

    function automatic logic cached(input addr_t a);
        logic [INDEX_BITS-1:0] idx;
        idx = a[INDEX_BITS:1];
        return mc_valid[idx] && (mc_tag[idx] == a[31:INDEX_BITS+1]);
    endfunction

    task automatic mark_filled(input addr_t a);
        mc_valid[a[INDEX_BITS:1]] = 1'b1;
        mc_tag[a[INDEX_BITS:1]]   = a[31:INDEX_BITS+1];
    endtask

    task automatic compare_word(input string field, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("CHECK FAILED %0s %0s expected %h actual %h",
                     cur_name, field, expected, actual);
        end
    endtask

    // length rule, low two bits not 11 is a 16-bit instruction
    task automatic build_expected(input addr_t start, input int count);
        addr_t       pc;
        logic [15:0] lo;
        pc = start;
        for (int i = 0; i < count; i++) begin
            lo = read_half(pc);
            exp_pc_q.push_back(pc);
            if (lo[1:0] != 2'b11) begin
                exp_inst_q.push_back({16'h0, lo});
                exp_rvc_q.push_back(1'b1);
                pc = pc + 32'd2;
            end else begin
                exp_inst_q.push_back({read_half(pc + 32'd2), lo});
                exp_rvc_q.push_back(1'b0);
                pc = pc + 32'd4;
            end
        end
    endtask

    task automatic read_tests();
        int               fd;
        int               code;
        logic [8*24-1:0]  kind;
        logic [8*24-1:0]  name;
        logic [8*128-1:0] rest;
        addr_t            a;
        logic [15:0]      d;
        int               cnt;
        int               pct;
        fd = $fopen("verif/fetch_front_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open verif/fetch_front_tests.txt");
            return;
        end
        code = $fscanf(fd, "%s", kind);
        while (code == 1) begin
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "mem") begin
                code = $fscanf(fd, "%h %h", a, d);
                if (a < 32'd512 && !a[0]) begin
                    image[a[8:1]] = d;
                end else begin
                    other_errors++;
                    $display("memory line address %h is outside the image", a);
                end
            end else if (kind == "test" && n_tests < MAX_TESTS) begin
                code = $fscanf(fd, "%s %h %d %d", name, a, cnt, pct);
                t_name[n_tests]  = name;
                t_pc[n_tests]    = a;
                t_count[n_tests] = cnt;
                t_ready[n_tests] = pct;
                n_tests++;
            end else begin
                other_errors++;
                $display("unexpected line in the tests file starting with %0s", kind);
                code = $fgets(rest, fd);
            end
            code = $fscanf(fd, "%s", kind);
        end
        $fclose(fd);
    endtask

    task automatic print_counts();
        $display("errors: %0d wrong values, %0d other, %0d instructions checked",
                 value_errors, other_errors, checked);
    endtask

    // memory side, credits and in-order responses
    always @(negedge clk_in) begin
        mem_credit     = 1'b0;
        mem_resp_valid = 1'b0;
        if (credit_pending > 0) begin
            mem_credit = 1'b1;
            credit_pending--;
        end
        if (resp_q.size() != 0 && cycle_cnt >= int'(resp_q[0][63:32])) begin
            resp_addr_cur  = resp_q[0][31:0];
            resp_q.delete(0);
            mem_resp_data  = {read_half(resp_addr_cur + 32'd2), read_half(resp_addr_cur)};
            mem_resp_valid = 1'b1;
        end
    end

    always @(posedge clk_in) begin
        if (rst_in) begin
            since_reset = 0;
            outstanding = 0;
            held        = 1'b0;
            resp_q.delete();
            for (int i = 0; i < CACHE_SIZE; i++) begin
                mc_valid[i] = 1'b0;
            end
        end else begin
            if (mem_credit) begin
                outstanding--;
            end
            if (mem_req_valid) begin
                assert (since_reset >= 2) else begin
                    other_errors++;
                    $display("memory request only %0d cycles after reset", since_reset);
                end
                assert (outstanding < MEM_CREDITS) else begin
                    other_errors++;
                    $display("memory request for %h sent with no credit left", mem_req_addr);
                end
                assert (!(cached(mem_req_addr) && cached(mem_req_addr + 32'd2))) else begin
                    other_errors++;
                    $display("memory request for %h, which is already cached", mem_req_addr);
                end
                outstanding++;
                credit_pending++;
                resp_q.push_back({32'(cycle_cnt + $urandom_range(6, 1)), mem_req_addr});
            end
            if (mem_resp_valid) begin
                mark_filled(resp_addr_cur);
                mark_filled(resp_addr_cur + 32'd2);
            end
            if (held && !redirect_valid) begin
                assert (inst_valid) else begin
                    other_errors++;
                    $display("instruction at %h dropped while the decoder stalled", held_pc);
                end
                if (inst_valid) begin
                    compare_word("held inst", held_inst, inst);
                    compare_word("held pc", held_pc, inst_pc);
                end
            end
            if (inst_valid && inst_ready) begin
                if (exp_pc_q.size() == 0) begin
                    other_errors++;
                    $display("instruction at %h accepted outside a test", inst_pc);
                end else begin
                    compare_word("pc", exp_pc_q.pop_front(), inst_pc);
                    compare_word("inst", exp_inst_q.pop_front(), inst);
                    compare_word("compressed", {31'h0, exp_rvc_q.pop_front()},
                                 {31'h0, inst_compressed});
                    checked++;
                end
            end
            held      = inst_valid && !inst_ready;
            held_inst = inst;
            held_pc   = inst_pc;
            since_reset++;
        end
        cycle_cnt++;
    end

    initial begin
        int total;
        void'($urandom(32'h61b8));
        rst_in         = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        inst_ready     = 1'b0;
        mem_credit     = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        n_tests        = 0;
        value_errors   = 0;
        other_errors   = 0;
        checked        = 0;
        credit_pending = 0;
        cycle_cnt      = 0;
        held           = 1'b0;
        cur_name       = "reset";
        total          = 0;
        for (int i = 0; i < 256; i++) begin
            image[i] = fill_pattern(32'(i * 2));
        end
        read_tests();
        for (int k = 0; k < n_tests; k++) begin
            total += t_count[k];
        end
        limit_cycles = 200 * total;
        repeat (2) @(negedge clk_in);
        rst_in = 1'b0;
        for (int k = 0; k < n_tests; k++) begin
            @(negedge clk_in);
            redirect_valid = 1'b1;
            redirect_pc    = t_pc[k];
            inst_ready     = 1'b0;
            cur_name       = t_name[k];
            build_expected(t_pc[k], t_count[k]);
            do begin
                @(negedge clk_in);
                redirect_valid = 1'b0;
                inst_ready = (exp_pc_q.size() != 0) && ($urandom_range(99, 0) < t_ready[k]);
            end while (exp_pc_q.size() != 0);
        end
        repeat (20) @(negedge clk_in);
        print_counts();
        if (value_errors == 0 && other_errors == 0 && n_tests != 0 && checked == total) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_in);
        $display("watchdog expired after %0d cycles, %0d instructions never arrived",
                 limit_cycles, exp_pc_q.size());
        print_counts();
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: fetch_front.f
hw/fetch_pkg.sv
hw/miss_if.sv
hw/icache.sv
hw/line_fill.sv
hw/fetch_align.sv
hw/fetch_front.sv
verif/fetch_front_tb.sv

// File: Bender.yml
package:
  name: fetch_front

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/miss_if.sv
      - hw/icache.sv
      - hw/line_fill.sv
      - hw/fetch_align.sv
      - hw/fetch_front.sv
  - target: simulation
    files:
      - verif/fetch_front_tb.sv

// File: verif/fetch_front_tests.txt
# mem <halfword address> <halfword data>, both hex
# test <name> <start pc hex> <instruction count> <inst_ready percent>
mem 0000 0513
mem 0002 0050
mem 0004 4581
mem 0006 0593
mem 0008 00a5
mem 000a 0505
mem 000c 0001
mem 000e 0633
mem 0010 00b5
mem 0012 4705
mem 0014 0293
mem 0016 0010
mem 0018 8082
mem 001a 0713
mem 001c 0027
mem 001e 0785
mem 0020 07b3
mem 0022 00f7
mem 0024 4501
mem 0026 0e63
mem 0028 00b5
mem 002a 0001
mem 002c 0001
mem 002e 0893
mem 0030 0300
mem 0032 1141
mem 0034 c606
mem 0036 0513
mem 0038 0ff0
mem 003a 40b2
mem 003c 0141
mem 003e 8082
mem 0040 0537
mem 0042 1234
test cold_stream   00000000 12 100
test mixed_lengths 00000020 12 100
test warm_repeat   00000000 12 100
test redirect_mid  0000001a 5 100
test back_pressure 00000004 20 40
test odd_start     0000000e 4 70
test tail_pressure 00000036 5 60
